// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --assert --top-module uart_peri_tb -f filelist.f -Mdir obj_dir
	./obj_dir/Vuart_peri_tb

clean:
	rm -rf obj_dir

// File: common/uart_line_pkg.sv
//////////////////////////////
// UART line definitions
// 8N1 frame constants, shifter states
// and the RX FIFO entry
//////////////////////////////

package uart_line_pkg;

    localparam int unsigned DATA_W  = 8;   // payload bits
    localparam int unsigned BIT_NUM = 10;  // start + data + stop

    // shared by both shifters
    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } line_state_e;

    // ferr sits above data so bit 8 carries it on the bus
    typedef struct packed {
        logic              ferr;  // stop bit sampled low
        logic [DATA_W-1:0] data;  // received byte
    } rx_entry_t;

endpackage

// File: common/uart_reg_pkg.sv
//////////////////////////////
// UART register map
// bus addresses and the configuration
// struct that leaves the register block
//////////////////////////////

package uart_reg_pkg;

    localparam int unsigned ADDR_W    = 4;   // bus address width
    localparam int unsigned BDR_MAX_W = 16;  // widest baud divisor
    localparam int unsigned LVL_MAX_W = 16;  // widest irq level

    // register addresses
    typedef enum logic [ADDR_W-1:0] {
        TX_DATA  = 4'h0,  // push into TX FIFO
        TX_LOAD  = 4'h1,  // TX FIFO occupancy
        TX_BAUD  = 4'h2,  // TX bit period minus one
        TX_LEVEL = 4'h4,  // irq_tx threshold
        RX_DATA  = 4'h8,  // pop from RX FIFO
        RX_LOAD  = 4'h9,  // RX FIFO occupancy
        RX_BAUD  = 4'ha,  // RX bit period minus one
        RX_PHASE = 4'hb,  // RX sample phase
        RX_LEVEL = 4'hc   // irq_rx threshold
    } reg_addr_e;

    // runtime configuration, upper bits stay zero past BDR_W
    typedef struct packed {
        logic [BDR_MAX_W-1:0] tx_bdr;    // tx divisor
        logic [BDR_MAX_W-1:0] rx_bdr;    // rx divisor
        logic [BDR_MAX_W-1:0] rx_smp;    // rx sample point
        logic [LVL_MAX_W-1:0] tx_level;  // irq when load below
        logic [LVL_MAX_W-1:0] rx_level;  // irq when load above
    } uart_cfg_t;

endpackage

// File: design/uart_baud_timer.sv
//////////////////////////////
// UART baud timer
// counts one bit period, pulses at the
// period end and at the sample phase
//////////////////////////////

`timescale 1ns/1ns

module uart_baud_timer #(
    parameter int unsigned BDR_W = 8
)(
    input  logic             clk,
    input  logic             rst,
    input  logic             run,      // held high while framing
    input  logic [BDR_W-1:0] bdr,      // period minus one
    input  logic [BDR_W-1:0] smp,      // sample phase
    output logic             bit_end,  // last cycle of a bit
    output logic             sample    // sample cycle inside a bit
);

    logic [BDR_W-1:0] cnt;  // position inside the bit

    // counter clears while idle and wraps at bdr
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (!run || bit_end) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // pulses, only while running
    assign bit_end = run && (cnt == bdr);  // period P = bdr+1
    assign sample  = run && (cnt == smp);

endmodule

// File: design/uart_des.sv
//////////////////////////////
// UART deserializer
// finds the start edge, samples 8N1
// bits and flags a low stop bit
//////////////////////////////

`timescale 1ns/1ns

module uart_des #(
    parameter int unsigned BDR_W = 8,
    localparam int unsigned BCN_W = $clog2(uart_line_pkg::DATA_W)
)(
    input  logic                     clk,
    input  logic                     rst,
    input  uart_reg_pkg::uart_cfg_t   cfg,
    input  logic                     rxd,    // asynchronous line
    output logic                     push,   // one-cycle write to RX FIFO
    output uart_line_pkg::rx_entry_t entry
);

    uart_line_pkg::line_state_e state;
    logic [1:0]       rxd_sync;  // two-flop synchronizer
    logic             rxd_s;     // synchronized line
    logic             rxd_prev;  // for edge detect
    logic             fall;
    logic             sample;
    logic [BCN_W-1:0] bit_cnt;   // data bits taken
    logic [uart_line_pkg::DATA_W-1:0] dat_q;  // shift in, LSB first
    logic             ferr_q;

    //////////////////////////////
    // line input
    //////////////////////////////

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rxd_sync <= '1;  // idle high, no false edge
            rxd_prev <= 1'b1;
        end else begin
            rxd_sync <= {rxd_sync[0], rxd};
            rxd_prev <= rxd_s;
        end
    end

    assign rxd_s = rxd_sync[1];
    assign fall  = rxd_prev && !rxd_s;  // start edge

    // timer restarts at zero when leaving idle
    uart_baud_timer #(
        .BDR_W   (BDR_W)
    ) i_timer (
        .clk     (clk),
        .rst     (rst),
        .run     (state != uart_line_pkg::IDLE),
        .bdr     (cfg.rx_bdr[BDR_W-1:0]),
        .smp     (cfg.rx_smp[BDR_W-1:0]),
        .bit_end (),
        .sample  (sample)
    );

    //////////////////////////////
    // frame FSM
    //////////////////////////////

    // each sample moves one bit on
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state   <= uart_line_pkg::IDLE;
            bit_cnt <= '0;
            push    <= 1'b0;
            ferr_q  <= 1'b0;
        end else begin
            push <= 1'b0;
            case (state)
                uart_line_pkg::IDLE: begin
                    if (fall) state <= uart_line_pkg::START;
                end
                uart_line_pkg::START: begin
                    if (sample) begin
                        bit_cnt <= '0;
                        // high start bit was a glitch
                        state   <= rxd_s ? uart_line_pkg::IDLE : uart_line_pkg::DATA;
                    end
                end
                uart_line_pkg::DATA: begin
                    if (sample) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == BCN_W'(uart_line_pkg::DATA_W - 1)) begin
                            state <= uart_line_pkg::STOP;
                        end
                    end
                end
                uart_line_pkg::STOP: begin
                    if (sample) begin
                        ferr_q <= !rxd_s;  // stop bit must be high
                        push   <= 1'b1;
                        state  <= uart_line_pkg::IDLE;  // ready for next edge mid stop bit
                    end
                end
                default: state <= uart_line_pkg::IDLE;
            endcase
        end
    end

    // data shifter
    always_ff @(posedge clk) begin
        if ((state == uart_line_pkg::DATA) && sample) begin
            dat_q <= {rxd_s, dat_q[uart_line_pkg::DATA_W-1:1]};
        end
    end

    assign entry.data = dat_q;
    assign entry.ferr = ferr_q;

endmodule

// File: design/uart_fifo.sv
//////////////////////////////
// UART FIFO
// circular buffer with any payload type
// and an occupancy count
//////////////////////////////

`timescale 1ns/1ns

module uart_fifo #(
    parameter int unsigned SIZ = 16,
    parameter type payload_t = logic [7:0],
    localparam int unsigned ADR_W = $clog2(SIZ),
    localparam int unsigned CNT_W = $clog2(SIZ+1)
)(
    input  logic             clk,
    input  logic             rst,
    // write side
    input  logic             in_vld,    // push strobe
    input  payload_t         in_dat,
    output logic             full,
    // read side
    output logic             out_vld,   // level, head is valid
    output payload_t         out_dat,
    input  logic             out_take,  // pop strobe
    // status
    output logic [CNT_W-1:0] cnt
);

    payload_t         mem [SIZ];  // storage
    logic [ADR_W-1:0] wr_ptr;
    logic [ADR_W-1:0] rd_ptr;
    logic             push;       // accepted write
    logic             pop;        // accepted read

    assign full    = (cnt == CNT_W'(SIZ));
    assign out_vld = (cnt != '0);
    assign push    = in_vld && !full;     // dropped when full
    assign pop     = out_take && out_vld; // ignored when empty

    // pointers and count
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt    <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;  // wraps, SIZ is 2**n
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            // both at once leaves the count alone
            if (push && !pop) begin
                cnt <= cnt + 1'b1;
            end else if (pop && !push) begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // storage array
    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= in_dat;
    end

    assign out_dat = mem[rd_ptr];  // head entry

endmodule

// File: design/uart_peri.sv
//////////////////////////////
// UART peripheral
// bus registers, TX and RX FIFOs
// and the 8N1 shifters
//////////////////////////////

`timescale 1ns/1ns

module uart_peri #(
    parameter int unsigned FIFO_SIZ = 16,  // power of two
    parameter int unsigned BDR_W    = 8,   // up to 16
    localparam int unsigned CNT_W   = $clog2(FIFO_SIZ+1),
    localparam int unsigned AW      = uart_reg_pkg::ADDR_W
)(
    input  logic          clk,
    input  logic          rst,
    // bus
    input  logic          wen,
    input  logic [AW-1:0] wad,
    input  logic [31:0]   wdt,
    input  logic          ren,
    input  logic [AW-1:0] rad,
    output logic [31:0]   rdt,
    // line
    input  logic          rxd,
    output logic          txd,
    // interrupts
    output logic          irq_tx,
    output logic          irq_rx
);

    uart_reg_pkg::uart_cfg_t   cfg;
    logic                     tx_push, tx_vld, tx_take;
    logic [7:0]               tx_dat, tx_head;
    logic [CNT_W-1:0]         tx_cnt, rx_cnt;
    logic                     rx_push, rx_vld, rx_pop;
    uart_line_pkg::rx_entry_t rx_entry, rx_head;

    uart_regs #(.FIFO_SIZ (FIFO_SIZ), .BDR_W (BDR_W)) i_regs (
        .clk     (clk),     .rst     (rst),
        .wen     (wen),     .wad     (wad),     .wdt     (wdt),
        .ren     (ren),     .rad     (rad),     .rdt     (rdt),
        .cfg     (cfg),
        .tx_push (tx_push), .tx_dat  (tx_dat),
        .rx_pop  (rx_pop),  .rx_head (rx_head), .rx_vld  (rx_vld),
        .tx_cnt  (tx_cnt),  .rx_cnt  (rx_cnt),
        .irq_tx  (irq_tx),  .irq_rx  (irq_rx)
    );

    // TX path
    uart_fifo #(.SIZ (FIFO_SIZ), .payload_t (logic [uart_line_pkg::DATA_W-1:0])) i_tx_fifo (
        .clk     (clk),     .rst     (rst),
        .in_vld  (tx_push), .in_dat  (tx_dat),  .full    (),
        .out_vld (tx_vld),  .out_dat (tx_head), .out_take (tx_take),
        .cnt     (tx_cnt)
    );

    uart_ser #(.BDR_W (BDR_W)) i_ser (
        .clk  (clk),    .rst  (rst),    .cfg  (cfg),
        .vld  (tx_vld), .dat  (tx_head), .take (tx_take),
        .txd  (txd)
    );

    // RX path
    uart_des #(.BDR_W (BDR_W)) i_des (
        .clk   (clk),     .rst   (rst),     .cfg   (cfg),
        .rxd   (rxd),     .push  (rx_push), .entry (rx_entry)
    );

    uart_fifo #(.SIZ (FIFO_SIZ), .payload_t (uart_line_pkg::rx_entry_t)) i_rx_fifo (
        .clk     (clk),     .rst     (rst),
        .in_vld  (rx_push), .in_dat  (rx_entry), .full     (),
        .out_vld (rx_vld),  .out_dat (rx_head),  .out_take (rx_pop),
        .cnt     (rx_cnt)
    );

endmodule

// File: design/uart_regs.sv
//////////////////////////////
// UART register block
// config flops, read mux, FIFO
// strobes and interrupt compares
//////////////////////////////

`timescale 1ns/1ns

module uart_regs #(
    parameter int unsigned FIFO_SIZ = 16,
    parameter int unsigned BDR_W    = 8,
    localparam int unsigned CNT_W   = $clog2(FIFO_SIZ+1),
    localparam int unsigned AW      = uart_reg_pkg::ADDR_W,
    localparam int unsigned BMW     = uart_reg_pkg::BDR_MAX_W,
    localparam int unsigned LMW     = uart_reg_pkg::LVL_MAX_W
)(
    input  logic                     clk,
    input  logic                     rst,
    // bus
    input  logic                     wen,
    input  logic [AW-1:0]            wad,
    input  logic [31:0]              wdt,
    input  logic                     ren,
    input  logic [AW-1:0]            rad,
    output logic [31:0]              rdt,
    // config out
    output uart_reg_pkg::uart_cfg_t   cfg,
    // FIFO strobes
    output logic                     tx_push,
    output logic [7:0]               tx_dat,
    output logic                     rx_pop,
    input  uart_line_pkg::rx_entry_t rx_head,
    input  logic                     rx_vld,
    input  logic [CNT_W-1:0]         tx_cnt,
    input  logic [CNT_W-1:0]         rx_cnt,
    // interrupts
    output logic                     irq_tx,
    output logic                     irq_rx
);

    //////////////////////////////
    // write side
    //////////////////////////////

    // written values keep only BDR_W or CNT_W bits
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cfg <= '0;
        end else if (wen) begin
            case (uart_reg_pkg::reg_addr_e'(wad))
                uart_reg_pkg::TX_BAUD:  cfg.tx_bdr   <= BMW'(wdt[BDR_W-1:0]);
                uart_reg_pkg::TX_LEVEL: cfg.tx_level <= LMW'(wdt[CNT_W-1:0]);
                uart_reg_pkg::RX_BAUD:  cfg.rx_bdr   <= BMW'(wdt[BDR_W-1:0]);
                uart_reg_pkg::RX_PHASE: cfg.rx_smp   <= BMW'(wdt[BDR_W-1:0]);
                uart_reg_pkg::RX_LEVEL: cfg.rx_level <= LMW'(wdt[CNT_W-1:0]);
                default: ;  // data and load are not config
            endcase
        end
    end

    // TX data goes straight to the FIFO, dropped there when full
    assign tx_push = wen && (wad == AW'(uart_reg_pkg::TX_DATA));
    assign tx_dat  = wdt[7:0];

    //////////////////////////////
    // read side
    //////////////////////////////

    always_comb begin
        rdt = '0;  // reserved and write-only read zero
        case (uart_reg_pkg::reg_addr_e'(rad))
            uart_reg_pkg::TX_LOAD:  rdt = 32'(tx_cnt);
            uart_reg_pkg::TX_BAUD:  rdt = 32'(cfg.tx_bdr);
            uart_reg_pkg::TX_LEVEL: rdt = 32'(cfg.tx_level);
            uart_reg_pkg::RX_DATA:  rdt = rx_vld ? 32'(rx_head) : '0;  // ferr in bit 8
            uart_reg_pkg::RX_LOAD:  rdt = 32'(rx_cnt);
            uart_reg_pkg::RX_BAUD:  rdt = 32'(cfg.rx_bdr);
            uart_reg_pkg::RX_PHASE: rdt = 32'(cfg.rx_smp);
            uart_reg_pkg::RX_LEVEL: rdt = 32'(cfg.rx_level);
            default: ;
        endcase
    end

    // reading data pops on the same edge
    assign rx_pop = ren && (rad == AW'(uart_reg_pkg::RX_DATA));

    // interrupt levels
    assign irq_tx = (tx_cnt < cfg.tx_level[CNT_W-1:0]);  // room to refill
    assign irq_rx = (rx_cnt > cfg.rx_level[CNT_W-1:0]);  // data to drain

endmodule

// File: design/uart_ser.sv
//////////////////////////////
// UART serializer
// frames TX FIFO bytes as 8N1
// onto the line, LSB first
//////////////////////////////

`timescale 1ns/1ns

module uart_ser #(
    parameter int unsigned BDR_W = 8,
    localparam int unsigned BCN_W = $clog2(uart_line_pkg::BIT_NUM)
)(
    input  logic                   clk,
    input  logic                   rst,
    input  uart_reg_pkg::uart_cfg_t cfg,
    // TX FIFO head
    input  logic                   vld,
    input  logic [7:0]             dat,
    output logic                   take,  // one-cycle pop
    // line
    output logic                   txd
);

    uart_line_pkg::line_state_e state;
    logic [uart_line_pkg::BIT_NUM-1:0] shr;  // frame shifter, bit 0 on the line
    logic [BCN_W-1:0] bit_cnt;               // bits left after the current one
    logic             bit_end;

    // bit period source, sample phase unused
    uart_baud_timer #(
        .BDR_W   (BDR_W)
    ) i_timer (
        .clk     (clk),
        .rst     (rst),
        .run     (state != uart_line_pkg::IDLE),
        .bdr     (cfg.tx_bdr[BDR_W-1:0]),
        .smp     ('0),
        .bit_end (bit_end),
        .sample  ()
    );

    // load from idle, or right at the end of a stop bit for gapless frames
    assign take = vld && ((state == uart_line_pkg::IDLE) ||
                          ((state == uart_line_pkg::STOP) && bit_end));

    //////////////////////////////
    // frame FSM
    //////////////////////////////

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state   <= uart_line_pkg::IDLE;
            shr     <= '1;  // line idles high
            bit_cnt <= '0;
        end else if (take) begin
            state   <= uart_line_pkg::START;
            shr     <= {1'b1, dat, 1'b0};  // stop, data, start
            bit_cnt <= BCN_W'(uart_line_pkg::BIT_NUM - 1);
        end else if (bit_end) begin
            shr     <= {1'b1, shr[uart_line_pkg::BIT_NUM-1:1]};  // ones fill in
            bit_cnt <= bit_cnt - 1'b1;
            case (state)
                uart_line_pkg::START: state <= uart_line_pkg::DATA;
                uart_line_pkg::DATA: begin
                    if (bit_cnt == BCN_W'(1)) state <= uart_line_pkg::STOP;  // last data bit
                end
                uart_line_pkg::STOP:  state <= uart_line_pkg::IDLE;  // nothing queued
                default:              state <= uart_line_pkg::IDLE;
            endcase
        end
    end

    assign txd = shr[0];  // registered line

endmodule

// File: dv/uart_peri_checker.sv
//////////////////////////////
// UART peripheral checker
// line and interrupt properties,
// bound into the peripheral top
//////////////////////////////

`timescale 1ns/1ns

module uart_peri_checker (
    input logic                    clk,
    input logic                    rst,
    input logic                    txd,
    input logic                    wen,
    input logic [3:0]              wad,
    input logic                    tx_take,  // serializer loads a frame
    input logic                    tx_b0,    // data bit 0 of that frame
    input uart_reg_pkg::uart_cfg_t cfg,
    input logic                    rx_push,
    input logic                    irq_rx
);

    logic        wr_seen;     // a TX_DATA write happened
    logic [16:0] start_left;  // start bit cycles still to come
    logic        start_b0;    // first data bit after the start bit

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            wr_seen    <= 1'b0;
            start_left <= '0;
            start_b0   <= 1'b0;
        end else begin
            if (wen && (wad == uart_reg_pkg::TX_DATA)) wr_seen <= 1'b1;
            if (tx_take) begin
                start_left <= {1'b0, cfg.tx_bdr} + 17'd1;  // P = bdr+1
                start_b0   <= tx_b0;
            end else if (start_left != '0) begin
                start_left <= start_left - 17'd1;
            end
        end
    end

    // line idles high until software sends
    idle_high: assert property (@(posedge clk) disable iff (rst) !wr_seen |-> txd)
        else $error("txd left the idle level before any TX_DATA write");

    // start bit low for all P cycles
    start_low: assert property (@(posedge clk) disable iff (rst) (start_left != '0) |-> !txd)
        else $error("start bit ended before P cycles");

    // and bit 0 follows right after
    start_end: assert property (@(posedge clk) disable iff (rst)
        (start_left == 17'd1) |=> (txd == start_b0))
        else $error("start bit not followed by data bit 0 after P cycles");

    irq_rise: assert property (@(posedge clk) disable iff (rst) $rose(irq_rx) |-> $past(rx_push))
        else $error("irq_rx rose without a receive push");

endmodule

bind uart_peri uart_peri_checker i_checker (
    .clk     (clk),
    .rst     (rst),
    .txd     (txd),
    .wen     (wen),
    .wad     (wad),
    .tx_take (tx_take),
    .tx_b0   (tx_head[0]),
    .cfg     (cfg),
    .rx_push (rx_push),
    .irq_rx  (irq_rx)
);

// File: dv/uart_peri_tb.sv
//////////////////////////////
// UART peripheral testbench
// bus tasks, loopback and hand-driven
// line, register and irq checks
//////////////////////////////

`timescale 1ns/1ns

module uart_peri_tb;

    localparam int unsigned FIFO_SIZ = 16;
    localparam int unsigned BDR_W    = 8;
    localparam int unsigned CNT_W    = $clog2(FIFO_SIZ + 1);
    localparam logic [31:0] BDR_MASK = (32'd1 << BDR_W) - 32'd1;  // divisor bits kept
    localparam logic [31:0] LVL_MASK = (32'd1 << CNT_W) - 32'd1;  // level bits kept
    localparam int          P_MAX    = 7;                         // slowest bit period used
    localparam int          TIMEOUT  = 12 * 10 * P_MAX + 2000;

    logic        clk, rst, wen, ren, rxd, txd, irq_tx, irq_rx;
    logic [3:0]  wad, rad;
    logic [31:0] wdt, rdt;
    logic        loop_en;           // rxd follows txd
    logic        rxd_drv;           // hand-made line
    logic        snap_tx, snap_rx;  // irqs seen with the last read
    logic [31:0] lcg_state;
    logic [7:0]  exp_q[$];          // bytes on their way
    int          cycles = 0;

    assign rxd = loop_en ? txd : rxd_drv;

    uart_peri #(.FIFO_SIZ (FIFO_SIZ), .BDR_W (BDR_W)) i_dut (
        .clk    (clk),    .rst    (rst),
        .wen    (wen),    .wad    (wad),    .wdt    (wdt),
        .ren    (ren),    .rad    (rad),    .rdt    (rdt),
        .rxd    (rxd),    .txd    (txd),
        .irq_tx (irq_tx), .irq_rx (irq_rx)
    );

    always #20 clk = ~clk;  // 40 ns period

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT) begin
            $display("Timeout: the test did not finish within %0d cycles", TIMEOUT);
            fail_stop();
        end
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    task automatic fail_stop();
        $display("RESULT: FAIL");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Error: %0t ns %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            fail_stop();
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic rand_byte(output logic [7:0] b);
        lcg_state = lcg_next(lcg_state);
        b = lcg_state[23:16];  // upper bits mix better
    endtask

    // all bus tasks start and end on a falling edge
    task automatic bus_write(input logic [3:0] addr, input logic [31:0] data);
        wen = 1'b1;
        wad = addr;
        wdt = data;
        @(negedge clk);
        wen = 1'b0;
    endtask

    task automatic bus_read(input logic [3:0] addr, input logic pop, output logic [31:0] data);
        rad = addr;
        ren = pop;
        #5;
        data    = rdt;  // combinational read, mid low phase
        snap_tx = irq_tx;
        snap_rx = irq_rx;
        @(negedge clk);
        ren = 1'b0;
    endtask

    task automatic send_byte(input logic [7:0] b);
        bus_write(uart_reg_pkg::TX_DATA, {24'd0, b});
        exp_q.push_back(b);
    endtask

    // write with an idle serializer, start bit 2 edges later
    task automatic send_first(input logic [7:0] b);
        wen = 1'b1;
        wad = uart_reg_pkg::TX_DATA;
        wdt = {24'd0, b};
        @(negedge clk);  // FIFO push edge
        wen = 1'b0;
        check_val("txd", {31'd0, txd}, 32'd1);
        @(negedge clk);  // take edge
        check_val("txd", {31'd0, txd}, 32'd0);
        exp_q.push_back(b);
    endtask

    task automatic set_baud(input logic [31:0] bdr, input logic [31:0] smp);
        bus_write(uart_reg_pkg::TX_BAUD, bdr);
        bus_write(uart_reg_pkg::RX_BAUD, bdr);
        bus_write(uart_reg_pkg::RX_PHASE, smp);
    endtask

    task automatic cfg_check(input logic [3:0] addr, input logic [31:0] mask);
        logic [31:0] w;
        logic [31:0] v;
        lcg_state = lcg_next(lcg_state);
        w = lcg_state;
        bus_write(addr, w);
        bus_read(addr, 1'b0, v);
        check_val($sformatf("reg 0x%0h", addr), v, w & mask);
    endtask

    task automatic wait_load(input logic [3:0] addr, input logic [31:0] target);
        logic [31:0] v;
        bus_read(addr, 1'b0, v);
        while (v != target) bus_read(addr, 1'b0, v);
    endtask

    task automatic drain(input int n);
        logic [31:0] v;
        logic [7:0]  e;
        int          i;
        for (i = 0; i < n; i++) begin
            bus_read(uart_reg_pkg::RX_DATA, 1'b1, v);  // pops on this edge
            e = exp_q.pop_front();
            check_val("RX_DATA", v, {24'd0, e});  // ferr clear
        end
    endtask

    // 8N1 frame on rxd, p cycles per bit
    task automatic drive_frame(input logic [7:0] b, input logic stop, input int p);
        int i;
        rxd_drv = 1'b0;
        repeat (p) @(negedge clk);
        for (i = 0; i < 8; i++) begin
            rxd_drv = b[i];  // LSB first
            repeat (p) @(negedge clk);
        end
        rxd_drv = stop;
        repeat (p) @(negedge clk);
        rxd_drv = 1'b1;
    endtask

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial begin
        logic [31:0] v;
        logic [31:0] w;
        logic [7:0]  b;
        int          i;
        clk       = 1'b0;
        rst       = 1'b1;
        wen       = 1'b0;
        ren       = 1'b0;
        wad       = '0;
        rad       = '0;
        wdt       = '0;
        loop_en   = 1'b1;
        rxd_drv   = 1'b1;
        lcg_state = 32'h2136;
        repeat (8) @(negedge clk);
        rst = 1'b0;

        // reset values, every address reads zero
        check_val("txd", {31'd0, txd}, 32'd1);
        check_val("irq_tx", {31'd0, irq_tx}, 32'd0);
        check_val("irq_rx", {31'd0, irq_rx}, 32'd0);
        for (i = 0; i < 16; i++) begin
            bus_read(i[3:0], 1'b0, v);
            check_val($sformatf("reg 0x%0h", i), v, 32'd0);
        end

        // config readback, masked widths
        for (i = 0; i < 3; i++) begin
            cfg_check(uart_reg_pkg::TX_BAUD, BDR_MASK);
            cfg_check(uart_reg_pkg::RX_BAUD, BDR_MASK);
            cfg_check(uart_reg_pkg::RX_PHASE, BDR_MASK);
            cfg_check(uart_reg_pkg::TX_LEVEL, LVL_MASK);
            cfg_check(uart_reg_pkg::RX_LEVEL, LVL_MASK);
        end
        bus_write(uart_reg_pkg::TX_LEVEL, 32'd0);
        bus_write(uart_reg_pkg::RX_LEVEL, 32'd0);

        // loopback at P = 4
        set_baud(32'd3, 32'd2);
        rand_byte(b);
        send_first(b);
        for (i = 0; i < 7; i++) begin
            rand_byte(b);
            send_byte(b);
        end
        wait_load(uart_reg_pkg::RX_LOAD, 32'd8);
        drain(8);
        bus_read(uart_reg_pkg::RX_DATA, 1'b1, v);
        check_val("RX_DATA", v, 32'd0);  // empty

        // loopback at P = 7
        set_baud(32'd6, 32'd3);
        rand_byte(b);
        send_first(b);
        rand_byte(b);
        send_byte(b);
        wait_load(uart_reg_pkg::RX_LOAD, 32'd2);
        drain(2);

        // low stop bit on a hand-made frame
        set_baud(32'd3, 32'd2);
        rxd_drv = 1'b1;
        loop_en = 1'b0;
        repeat (4) @(negedge clk);
        rand_byte(b);
        drive_frame(b, 1'b0, 4);
        wait_load(uart_reg_pkg::RX_LOAD, 32'd1);
        bus_read(uart_reg_pkg::RX_DATA, 1'b1, v);
        check_val("RX_DATA", v, {23'd0, 1'b1, b});  // ferr in bit 8
        loop_en = 1'b1;

        // interrupt levels, compared every other cycle
        bus_write(uart_reg_pkg::TX_LEVEL, 32'd2);
        bus_write(uart_reg_pkg::RX_LEVEL, 32'd3);
        bus_read(uart_reg_pkg::TX_LOAD, 1'b0, v);
        check_val("irq_tx", {31'd0, snap_tx}, 32'd1);  // empty is below 2
        for (i = 0; i < 5; i++) begin
            rand_byte(b);
            send_byte(b);
        end
        w = '0;
        while (w != 32'd5) begin
            bus_read(uart_reg_pkg::TX_LOAD, 1'b0, v);
            check_val("irq_tx", {31'd0, snap_tx}, 32'(v < 32'd2));
            bus_read(uart_reg_pkg::RX_LOAD, 1'b0, w);
            check_val("irq_rx", {31'd0, snap_rx}, 32'(w > 32'd3));
        end
        for (i = 0; i < 5; i++) begin
            bus_read(uart_reg_pkg::RX_LOAD, 1'b0, w);
            check_val("irq_rx", {31'd0, snap_rx}, 32'(w > 32'd3));
            drain(1);
        end
        bus_read(uart_reg_pkg::RX_LOAD, 1'b0, w);
        check_val("RX_LOAD", w, 32'd0);
        check_val("irq_rx", {31'd0, snap_rx}, 32'd0);  // cleared by draining

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: filelist.f
common/uart_reg_pkg.sv
common/uart_line_pkg.sv
design/uart_baud_timer.sv
design/uart_fifo.sv
design/uart_ser.sv
design/uart_des.sv
design/uart_regs.sv
design/uart_peri.sv
dv/uart_peri_checker.sv
dv/uart_peri_tb.sv
